/* ex_pkg.sv */
package ex_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [2*WORD_W-1:0]   dword_t;    // {HI, LO}
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;
    typedef logic [5:0]            count_t;    // 0 to 32

    // Codes are fixed, the data file uses them
    typedef enum logic [4:0] {
        op_nop   = 5'd0,
        op_or    = 5'd1,
        op_and   = 5'd2,
        op_nor   = 5'd3,
        op_xor   = 5'd4,
        op_sll   = 5'd5,
        op_srl   = 5'd6,
        op_sra   = 5'd7,
        op_add   = 5'd8,
        op_addu  = 5'd9,
        op_sub   = 5'd10,
        op_subu  = 5'd11,
        op_slt   = 5'd12,
        op_sltu  = 5'd13,
        op_clz   = 5'd14,
        op_clo   = 5'd15,
        op_mul   = 5'd16,
        op_mult  = 5'd17,
        op_multu = 5'd18,
        op_mfhi  = 5'd19,
        op_mflo  = 5'd20,
        op_mthi  = 5'd21,
        op_mtlo  = 5'd22
    } ex_op_e;

    typedef enum logic [1:0] {
        res_logic_shift, res_arith, res_mul_low, res_hilo_move
    } res_sel_e;

    typedef enum logic [2:0] {
        lf_or, lf_and, lf_nor, lf_xor, lf_sll, lf_srl, lf_sra
    } logic_fn_e;

    typedef enum logic [2:0] {
        af_add, af_sub, af_slt, af_sltu, af_clz, af_clo
    } arith_fn_e;

    typedef enum logic [2:0] {
        hf_none, hf_wr_prod, hf_wr_hi, hf_wr_lo, hf_rd_hi, hf_rd_lo
    } hilo_fn_e;

endpackage

/* ex_ctrl_if.sv */
`timescale 1ns/100ps

interface ex_ctrl_if;
    import ex_pkg::*;

    logic      op_valid;    // Operation strobe for this cycle
    logic_fn_e logic_fn;
    arith_fn_e arith_fn;
    logic      mul_signed;
    hilo_fn_e  hilo_fn;

    modport ctrl (
        output op_valid,
        output logic_fn,
        output arith_fn,
        output mul_signed,
        output hilo_fn
    );

    modport ls (input logic_fn);

    modport arith (input arith_fn);

    modport mulhilo (
        input op_valid,
        input mul_signed,
        input hilo_fn
    );

endinterface

/* ex_control.sv */
`timescale 1ns/100ps

module ex_control (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              valid_i,
    input  ex_pkg::ex_op_e    aluop_i,
    input  ex_pkg::reg_addr_t wd_i,
    input  logic              wreg_i,
    input  ex_pkg::word_t     ls_result_i,
    input  ex_pkg::word_t     arith_result_i,
    input  logic              ovf_i,
    input  ex_pkg::word_t     mul_low_i,
    input  ex_pkg::word_t     hilo_result_i,
    ex_ctrl_if.ctrl           ctrl_if,
    output logic              valid_o,
    output ex_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output ex_pkg::word_t     wdata_o
);
    import ex_pkg::*;

    res_sel_e res_sel;
    logic     ovf_chk;    // Signed add/sub only
    word_t    result;

    always_comb begin
        ctrl_if.op_valid   = valid_i;
        ctrl_if.logic_fn   = lf_or;
        ctrl_if.arith_fn   = af_add;
        ctrl_if.mul_signed = 1'b0;
        ctrl_if.hilo_fn    = hf_none;
        res_sel            = res_hilo_move;    // hf_none reads back zero
        ovf_chk            = 1'b0;
        case (aluop_i)
            op_or:    begin res_sel = res_logic_shift; ctrl_if.logic_fn = lf_or;  end
            op_and:   begin res_sel = res_logic_shift; ctrl_if.logic_fn = lf_and; end
            op_nor:   begin res_sel = res_logic_shift; ctrl_if.logic_fn = lf_nor; end
            op_xor:   begin res_sel = res_logic_shift; ctrl_if.logic_fn = lf_xor; end
            op_sll:   begin res_sel = res_logic_shift; ctrl_if.logic_fn = lf_sll; end
            op_srl:   begin res_sel = res_logic_shift; ctrl_if.logic_fn = lf_srl; end
            op_sra:   begin res_sel = res_logic_shift; ctrl_if.logic_fn = lf_sra; end
            op_add:   begin res_sel = res_arith; ctrl_if.arith_fn = af_add; ovf_chk = 1'b1; end
            op_addu:  begin res_sel = res_arith; ctrl_if.arith_fn = af_add;  end
            op_sub:   begin res_sel = res_arith; ctrl_if.arith_fn = af_sub; ovf_chk = 1'b1; end
            op_subu:  begin res_sel = res_arith; ctrl_if.arith_fn = af_sub;  end
            op_slt:   begin res_sel = res_arith; ctrl_if.arith_fn = af_slt;  end
            op_sltu:  begin res_sel = res_arith; ctrl_if.arith_fn = af_sltu; end
            op_clz:   begin res_sel = res_arith; ctrl_if.arith_fn = af_clz;  end
            op_clo:   begin res_sel = res_arith; ctrl_if.arith_fn = af_clo;  end
            op_mul:   begin res_sel = res_mul_low; ctrl_if.mul_signed = 1'b1; end
            op_mult:  begin ctrl_if.hilo_fn = hf_wr_prod; ctrl_if.mul_signed = 1'b1; end
            op_multu: ctrl_if.hilo_fn = hf_wr_prod;
            op_mfhi:  ctrl_if.hilo_fn = hf_rd_hi;
            op_mflo:  ctrl_if.hilo_fn = hf_rd_lo;
            op_mthi:  ctrl_if.hilo_fn = hf_wr_hi;
            op_mtlo:  ctrl_if.hilo_fn = hf_wr_lo;
            default:  ;    // nop and unknown codes
        endcase
    end

    always_comb begin
        case (res_sel)
            res_logic_shift: result = ls_result_i;
            res_arith:       result = arith_result_i;
            res_mul_low:     result = mul_low_i;
            default:         result = hilo_result_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
            wd_o    <= '0;
            wreg_o  <= 1'b0;
            wdata_o <= '0;
        end else begin
            valid_o <= valid_i;
            wd_o    <= wd_i;
            wreg_o  <= valid_i & wreg_i & ~(ovf_chk & ovf_i);
            wdata_o <= result;
        end
    end

endmodule

/* ex_logic_shift.sv */
`timescale 1ns/100ps

module ex_logic_shift (
    input  ex_pkg::word_t reg1_i,
    input  ex_pkg::word_t reg2_i,
    ex_ctrl_if.ls         ctrl_if,
    output ex_pkg::word_t ls_result_o
);
    import ex_pkg::*;

    shamt_t shamt;
    word_t  sra_res;

    // Amount comes from reg1, upper bits ignored
    assign shamt = reg1_i[SHAMT_W-1:0];

    assign sra_res = word_t'($signed(reg2_i) >>> shamt);    // Sign fill

    always_comb begin
        case (ctrl_if.logic_fn)
            lf_or: begin
                ls_result_o = reg1_i | reg2_i;
            end
            lf_and: begin
                ls_result_o = reg1_i & reg2_i;
            end
            lf_nor: begin
                ls_result_o = ~(reg1_i | reg2_i);
            end
            lf_xor: begin
                ls_result_o = reg1_i ^ reg2_i;
            end
            lf_sll: begin
                ls_result_o = reg2_i << shamt;
            end
            lf_srl: begin
                ls_result_o = reg2_i >> shamt;
            end
            lf_sra: begin
                ls_result_o = sra_res;
            end
            default: begin
                ls_result_o = '0;
            end
        endcase
    end

endmodule

/* ex_arith.sv */
`timescale 1ns/100ps

module ex_arith (
    input  ex_pkg::word_t reg1_i,
    input  ex_pkg::word_t reg2_i,
    ex_ctrl_if.arith      ctrl_if,
    output ex_pkg::word_t arith_result_o,
    output logic          ovf_o
);
    import ex_pkg::*;

    word_t  reg2_mux;
    word_t  sum;
    logic   lt_signed;
    logic   lt_unsigned;
    count_t clz_cnt;
    count_t clo_cnt;

    // Position of the highest set bit gives the count
    function automatic count_t lead_zeros(input word_t w);
        count_t n;
        n = count_t'(WORD_W);
        for (int i = 0; i < WORD_W; i++) begin
            if (w[i]) begin
                n = count_t'(WORD_W - 1 - i);
            end
        end
        return n;
    endfunction

    // sub and slt add the two's complement
    assign reg2_mux = ((ctrl_if.arith_fn == af_sub) || (ctrl_if.arith_fn == af_slt)) ?
                      (~reg2_i + 1'b1) : reg2_i;

    assign sum = reg1_i + reg2_mux;

    assign ovf_o = (reg1_i[WORD_W-1] == reg2_mux[WORD_W-1]) &&
                   (sum[WORD_W-1] != reg1_i[WORD_W-1]);

    assign lt_signed = (reg1_i[WORD_W-1] && !reg2_i[WORD_W-1]) ||
                       (!reg1_i[WORD_W-1] && !reg2_i[WORD_W-1] && sum[WORD_W-1]) ||
                       (reg1_i[WORD_W-1] && reg2_i[WORD_W-1] && sum[WORD_W-1]);

    assign lt_unsigned = reg1_i < reg2_i;

    assign clz_cnt = lead_zeros(reg1_i);
    assign clo_cnt = lead_zeros(~reg1_i);    // Leading ones of reg1

    always_comb begin
        case (ctrl_if.arith_fn)
            af_add, af_sub: begin
                arith_result_o = sum;
            end
            af_slt: begin
                arith_result_o = word_t'(lt_signed);
            end
            af_sltu: begin
                arith_result_o = word_t'(lt_unsigned);
            end
            af_clz: begin
                arith_result_o = word_t'(clz_cnt);
            end
            af_clo: begin
                arith_result_o = word_t'(clo_cnt);
            end
            default: begin
                arith_result_o = '0;
            end
        endcase
    end

endmodule

/* ex_mul_hilo.sv */
`timescale 1ns/100ps

module ex_mul_hilo (
    input  logic          clk,
    input  logic          reset_i,
    input  ex_pkg::word_t reg1_i,
    input  ex_pkg::word_t reg2_i,
    ex_ctrl_if.mulhilo    ctrl_if,
    output ex_pkg::word_t mul_low_o,
    output ex_pkg::word_t hilo_result_o
);
    import ex_pkg::*;

    dword_t op_a;
    dword_t op_b;
    dword_t product;
    word_t  hi;
    word_t  lo;

    // Sign extend when signed, the low 64 bits are then right either way
    assign op_a = {{WORD_W{ctrl_if.mul_signed & reg1_i[WORD_W-1]}}, reg1_i};
    assign op_b = {{WORD_W{ctrl_if.mul_signed & reg2_i[WORD_W-1]}}, reg2_i};

    assign product = op_a * op_b;

    assign mul_low_o = product[WORD_W-1:0];

    // Same edge as the result register in ex_control
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hi <= '0;
            lo <= '0;
        end else if (ctrl_if.op_valid) begin
            case (ctrl_if.hilo_fn)
                hf_wr_prod: begin
                    hi <= product[2*WORD_W-1:WORD_W];
                    lo <= product[WORD_W-1:0];
                end
                hf_wr_hi: begin
                    hi <= reg1_i;    // LO kept
                end
                hf_wr_lo: begin
                    lo <= reg1_i;
                end
                default: begin
                end
            endcase
        end
    end

    // Zero for anything but a move-from
    always_comb begin
        case (ctrl_if.hilo_fn)
            hf_rd_hi: begin
                hilo_result_o = hi;
            end
            hf_rd_lo: begin
                hilo_result_o = lo;
            end
            default: begin
                hilo_result_o = '0;
            end
        endcase
    end

endmodule

/* ex_stage.sv */
`timescale 1ns/100ps

module ex_stage (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              valid_i,
    input  ex_pkg::ex_op_e    aluop_i,
    input  ex_pkg::word_t     reg1_i,
    input  ex_pkg::word_t     reg2_i,
    input  ex_pkg::reg_addr_t wd_i,
    input  logic              wreg_i,
    output logic              valid_o,
    output ex_pkg::reg_addr_t wd_o,
    output logic              wreg_o,
    output ex_pkg::word_t     wdata_o
);
    import ex_pkg::*;

    word_t ls_result;
    word_t arith_result;
    logic  ovf;
    word_t mul_low;
    word_t hilo_result;

    ex_ctrl_if ctrl_if ();

    ex_control u_control (
        .clk            (clk),
        .reset_i        (reset_i),
        .valid_i        (valid_i),
        .aluop_i        (aluop_i),
        .wd_i           (wd_i),
        .wreg_i         (wreg_i),
        .ls_result_i    (ls_result),
        .arith_result_i (arith_result),
        .ovf_i          (ovf),
        .mul_low_i      (mul_low),
        .hilo_result_i  (hilo_result),
        .ctrl_if        (ctrl_if.ctrl),
        .valid_o        (valid_o),
        .wd_o           (wd_o),
        .wreg_o         (wreg_o),
        .wdata_o        (wdata_o)
    );

    ex_logic_shift u_logic_shift (
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .ctrl_if     (ctrl_if.ls),
        .ls_result_o (ls_result)
    );

    ex_arith u_arith (
        .reg1_i         (reg1_i),
        .reg2_i         (reg2_i),
        .ctrl_if        (ctrl_if.arith),
        .arith_result_o (arith_result),
        .ovf_o          (ovf)
    );

    ex_mul_hilo u_mul_hilo (
        .clk           (clk),
        .reset_i       (reset_i),
        .reg1_i        (reg1_i),
        .reg2_i        (reg2_i),
        .ctrl_if       (ctrl_if.mulhilo),
        .mul_low_o     (mul_low),
        .hilo_result_o (hilo_result)
    );

endmodule

/* ex_stage_chk.sv */
`timescale 1ns/100ps

module ex_stage_chk (
    input logic              clk,
    input logic              reset_i,
    input logic              valid_i,
    input ex_pkg::reg_addr_t wd_i,
    input logic              valid_o,
    input ex_pkg::reg_addr_t wd_o,
    input logic              wreg_o
);

    int unsigned fail_cnt = 0;    // Read by the testbench at the end

    reset_clears_valid: assert property (@(posedge clk) reset_i |=> !valid_o)
        else begin
            fail_cnt++;
            $error("valid_o high in the cycle after reset");
        end

    wreg_needs_valid: assert property (@(posedge clk) wreg_o |-> valid_o)
        else begin
            fail_cnt++;
            $error("wreg_o high while valid_o is low");
        end

    valid_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        valid_i |=> valid_o)
        else begin
            fail_cnt++;
            $error("valid_i not followed by valid_o one cycle later");
        end

    // Address travels with its operation
    wd_follows: assert property (@(posedge clk) disable iff (reset_i)
        valid_o |-> (wd_o == $past(wd_i)))
        else begin
            fail_cnt++;
            $error("wd_o does not match wd_i of the previous cycle");
        end

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

/* tb_ex_stage.sv */
`timescale 1ns/100ps

module tb_ex_stage;
    import ex_pkg::*;

    localparam int CLK_PERIOD_NS  = 40;
    localparam int RESET_CYCLES   = 8;
    localparam int RESET_TIMEOUT  = 50;      // Cycles
    localparam int RUN_TIMEOUT_NS = 20000;
    localparam int MAX_VECS       = 64;
    localparam int VEC_FIELDS     = 8;
    localparam logic [31:0] END_MARK = 32'hff;

    logic      clk;
    logic      reset_i;
    logic      valid_i;
    ex_op_e    aluop_i;
    word_t     reg1_i;
    word_t     reg2_i;
    reg_addr_t wd_i;
    logic      wreg_i;
    logic      valid_o;
    reg_addr_t wd_o;
    logic      wreg_o;
    word_t     wdata_o;

    logic [31:0] vec_mem [0:MAX_VECS*VEC_FIELDS-1];

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clk_gen (.clk_o(clk));

    ex_stage dut_i (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .aluop_i (aluop_i),
        .reg1_i  (reg1_i),
        .reg2_i  (reg2_i),
        .wd_i    (wd_i),
        .wreg_i  (wreg_i),
        .valid_o (valid_o),
        .wd_o    (wd_o),
        .wreg_o  (wreg_o),
        .wdata_o (wdata_o)
    );

    bind ex_stage ex_stage_chk chk_i (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .wd_i    (wd_i),
        .valid_o (valid_o),
        .wd_o    (wd_o),
        .wreg_o  (wreg_o)
    );

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got,
                              input reg_addr_t expected);
        if (got !== expected) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expected);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, name, got, expected);
            abort_run();
        end
    endtask

    task automatic apply_vector(input int idx);
        int base;
        base    = idx * VEC_FIELDS;
        valid_i = vec_mem[base][0];
        aluop_i = ex_op_e'(vec_mem[base+1][4:0]);
        reg1_i  = vec_mem[base+2];
        reg2_i  = vec_mem[base+3];
        wd_i    = vec_mem[base+4][REG_ADDR_W-1:0];
        wreg_i  = vec_mem[base+5][0];
    endtask

    // Outputs of the record driven one cycle earlier
    task automatic check_result(input int idx);
        int base;
        base = idx * VEC_FIELDS;
        check_bit("valid_o", valid_o, vec_mem[base][0]);
        check_bit("wreg_o", wreg_o, vec_mem[base+7][0]);
        if (vec_mem[base][0]) begin
            check_addr("wd_o", wd_o, vec_mem[base+4][REG_ADDR_W-1:0]);
            check_word("wdata_o", wdata_o, vec_mem[base+6]);
        end
    endtask

    initial begin
        reset_i = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
    end

    initial begin
        #(RUN_TIMEOUT_NS);
        $display("error: simulation ran past its time limit");
        abort_run();
    end

    initial begin
        int   cycles;
        int   idx;
        logic done;
        valid_i = 1'b1;    // Active through reset, outputs must still clear
        aluop_i = op_nop;
        reg1_i  = '0;
        reg2_i  = '0;
        wd_i    = '0;
        wreg_i  = 1'b1;
        $readmemh("ex_stage_testdata.txt", vec_mem);

        cycles = 0;
        while (reset_i !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (reset_i !== 1'b0) begin
            $display("error: reset was not released in time");
            abort_run();
        end

        idx  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (idx > 0) begin
                check_result(idx - 1);
            end
            if (idx >= MAX_VECS || $isunknown(vec_mem[idx * VEC_FIELDS])) begin
                $display("error: data file missing or without end marker");
                abort_run();
            end
            if (vec_mem[idx * VEC_FIELDS] == END_MARK) begin
                valid_i = 1'b0;
                done    = 1'b1;
            end else begin
                apply_vector(idx);
                idx++;
            end
        end

        @(negedge clk);
        if (dut_i.chk_i.fail_cnt != 0) begin
            $display("error: %0d assertion failures", dut_i.chk_i.fail_cnt);
            abort_run();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

/* ex_stage.f */
ex_pkg.sv
ex_ctrl_if.sv
ex_control.sv
ex_logic_shift.sv
ex_arith.sv
ex_mul_hilo.sv
ex_stage.sv
ex_stage_chk.sv
tb_clk_gen.sv
tb_ex_stage.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ex_stage
FILELIST  = ex_stage.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

/* ex_stage_testdata.txt */
// Each line holds valid op reg1 reg2 wd wreg then the expected wdata and wreg_o
// All fields hex, ff in the valid column ends the list
1 13 00000000 00000000 01 1 00000000 1  // mfhi right after reset
1 01 f0f01234 0f0f00ff 02 1 ffff12ff 1
1 02 f0f01234 0ff000ff 03 1 00f00034 1
1 03 a5a50000 0000f00f 04 0 5a5a0ff0 0
1 04 ffff0000 12345678 05 1 edcb5678 1
0 08 00000001 00000001 06 1 00000000 0  // bubble
1 05 00000000 80000001 07 1 80000001 1
1 05 00000001 80000001 08 1 00000002 1
1 05 0000001f 00000003 09 1 80000000 1
1 06 ffffffe4 f0000000 0a 1 0f000000 1  // upper amount bits ignored
1 06 0000001f 80000000 0b 1 00000001 1
1 07 00000001 80000010 0c 1 c0000008 1
1 07 0000001f 80000000 0d 1 ffffffff 1
1 07 00000124 7ffffff0 0e 1 07ffffff 1
1 08 00000005 fffffffd 0f 1 00000002 1
1 08 7fffffff 00000001 10 1 80000000 0  // signed overflow
1 09 7fffffff 00000001 11 1 80000000 1
1 0a 00000003 00000005 12 1 fffffffe 1
1 0a 80000000 00000001 13 1 7fffffff 0
1 0b 80000000 00000001 14 1 7fffffff 1
1 0c ffffffff 00000001 15 1 00000001 1
1 0d ffffffff 00000001 16 1 00000000 1
1 0c 00000001 ffffffff 17 1 00000000 1
1 0d 00000001 ffffffff 18 1 00000001 1
1 0e 00000000 00000000 19 1 00000020 1
1 0e ffffffff 00000000 1a 1 00000000 1
1 0e 80000000 00000000 1b 1 00000000 1
1 0e 00000001 00000000 1c 1 0000001f 1
1 0f 00000000 00000000 1d 1 00000000 1
1 0f ffffffff 00000000 1e 1 00000020 1
1 0f 80000000 00000000 1f 1 00000001 1
1 0f fffffffe 00000000 01 1 0000001f 1
1 11 fffffffe 00000003 02 0 00000000 0  // mult -2 * 3
1 13 00000000 00000000 03 1 ffffffff 1
1 14 00000000 00000000 04 1 fffffffa 1
1 12 fffffffe 00000003 05 0 00000000 0  // multu
1 13 00000000 00000000 06 1 00000002 1
1 14 00000000 00000000 07 1 fffffffa 1
1 10 00012345 00001000 08 1 12345000 1
1 15 cafef00d 00000000 09 0 00000000 0  // mthi
0 15 deadbeef 00000000 0a 0 00000000 0  // bubble must not write HI
1 14 00000000 00000000 0b 1 fffffffa 1
1 13 00000000 00000000 0c 1 cafef00d 1
1 00 12345678 9abcdef0 0d 1 00000000 1
1 1f 12345678 9abcdef0 0e 1 00000000 1  // unknown code acts as nop
ff 0 0 0 0 0 0 0
